/* hw/backend_pkg.sv */
package backend_pkg;

	// datapath and register file
	localparam int DATA_W   = 16;
	localparam int NUM_REGS = 8;
	localparam int REG_W    = 3;
	localparam int IMM_W    = 8;

	// reorder buffer, tag indexes an entry directly
	localparam int ROB_DEPTH = 8;
	localparam int TAG_W     = 3;

	// in-flight counters must reach ROB_DEPTH itself
	localparam int CNT_W = $clog2(ROB_DEPTH + 1);

	// queues and units
	localparam int INSTR_CREDITS = 4;
	localparam int ISSUE_DEPTH   = 4;
	localparam int MUL_STAGES    = 3;

	typedef enum logic [1:0] {
		OP_LI,
		OP_ADD,
		OP_SUB,
		OP_MUL
	} op_e;

	// decoded instruction from the front end, 19 bits
	typedef struct packed {
		op_e              op;
		logic [REG_W-1:0] rd;
		logic [REG_W-1:0] rs1;
		logic [REG_W-1:0] rs2;
		logic [IMM_W-1:0] imm;
	} micro_instr_t;

	// issue payload, operands already read at dispatch
	typedef struct packed {
		op_e               op;
		logic [TAG_W-1:0]  tag;
		logic [DATA_W-1:0] src1;
		logic [DATA_W-1:0] src2;
		logic [IMM_W-1:0]  imm;
	} exe_param_t;

endpackage

/* hw/issue_fifo.sv */
`timescale 1ns/1ps

module issue_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int  DEPTH     = 4
) (
	input  logic     CLK,
	input  logic     i_arst_n,
	input  logic     i_push,
	input  payload_t i_data,
	input  logic     i_pop,
	output payload_t o_data,
	output logic     o_full,
	output logic     o_empty
);

	payload_t mem [DEPTH];
	logic [$clog2(DEPTH)-1:0] wr_ptr;
	logic [$clog2(DEPTH)-1:0] rd_ptr;
	logic [$clog2(DEPTH+1)-1:0] count;
	logic do_push;
	logic do_pop;

	assign do_push = i_push && !o_full;
	assign do_pop  = i_pop && !o_empty;

	always_ff @(posedge CLK or negedge i_arst_n) begin
		if (!i_arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (do_push) begin
			mem[wr_ptr] <= i_data;
		end
	end

	// head is visible before the pop
	assign o_data  = mem[rd_ptr];
	assign o_full  = (count == DEPTH);
	assign o_empty = (count == 0);

endmodule

/* hw/reorder_buf.sv */
`timescale 1ns/1ps

module reorder_buf (
	input  logic                           CLK,
	input  logic                           i_arst_n,
	input  logic                           i_alloc,
	input  logic [backend_pkg::REG_W-1:0]  i_alloc_rd,
	output logic [backend_pkg::TAG_W-1:0]  o_alloc_tag,
	output logic                           o_full,
	input  logic                           i_alu_done,
	input  logic [backend_pkg::TAG_W-1:0]  i_alu_tag,
	input  logic [backend_pkg::DATA_W-1:0] i_alu_data,
	input  logic                           i_mul_done,
	input  logic [backend_pkg::TAG_W-1:0]  i_mul_tag,
	input  logic [backend_pkg::DATA_W-1:0] i_mul_data,
	input  logic                           i_retire,
	output logic                           o_head_done,
	output logic [backend_pkg::REG_W-1:0]  o_head_rd,
	output logic [backend_pkg::DATA_W-1:0] o_head_data
);

	import backend_pkg::*;

	logic [REG_W-1:0]  ent_rd   [ROB_DEPTH];
	logic [DATA_W-1:0] ent_data [ROB_DEPTH];
	logic [ROB_DEPTH-1:0] ent_done;
	logic [TAG_W-1:0] head;
	logic [TAG_W-1:0] tail;
	logic [CNT_W-1:0] count;

	// pointers wrap by overflow, depth is a power of two
	always_ff @(posedge CLK or negedge i_arst_n) begin
		if (!i_arst_n) begin
			head     <= '0;
			tail     <= '0;
			count    <= '0;
			ent_done <= '0;
		end else begin
			if (i_alloc) begin
				tail           <= tail + 1'b1;
				ent_done[tail] <= 1'b0;
			end
			// both units may finish in the same cycle
			if (i_alu_done) begin
				ent_done[i_alu_tag] <= 1'b1;
			end
			if (i_mul_done) begin
				ent_done[i_mul_tag] <= 1'b1;
			end
			if (i_retire) begin
				head           <= head + 1'b1;
				ent_done[head] <= 1'b0;
			end
			case ({i_alloc, i_retire})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (i_alloc) begin
			ent_rd[tail] <= i_alloc_rd;
		end
		if (i_alu_done) begin
			ent_data[i_alu_tag] <= i_alu_data;
		end
		if (i_mul_done) begin
			ent_data[i_mul_tag] <= i_mul_data;
		end
	end

	assign o_alloc_tag = tail;
	assign o_full      = (count == ROB_DEPTH);
	assign o_head_done = ent_done[head];
	assign o_head_rd   = ent_rd[head];
	assign o_head_data = ent_data[head];

endmodule

/* hw/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
	input  logic                           CLK,
	input  logic                           i_arst_n,
	input  logic [backend_pkg::REG_W-1:0]  i_rs1,
	input  logic [backend_pkg::REG_W-1:0]  i_rs2,
	output logic [backend_pkg::DATA_W-1:0] o_rs1_data,
	output logic [backend_pkg::DATA_W-1:0] o_rs2_data,
	input  logic                           i_wr_en,
	input  logic [backend_pkg::REG_W-1:0]  i_wr_rd,
	input  logic [backend_pkg::DATA_W-1:0] i_wr_data
);

	import backend_pkg::*;

	logic [DATA_W-1:0] regs [NUM_REGS];

	// architectural state, only written at retirement
	always_ff @(posedge CLK or negedge i_arst_n) begin
		if (!i_arst_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (i_wr_en) begin
			regs[i_wr_rd] <= i_wr_data;
		end
	end

	// no bypass, scoreboard holds readers until the write lands
	assign o_rs1_data = regs[i_rs1];
	assign o_rs2_data = regs[i_rs2];

endmodule

/* hw/alu_unit.sv */
`timescale 1ns/1ps

module alu_unit (
	input  logic                           CLK,
	input  logic                           i_arst_n,
	input  logic                           i_valid,
	input  backend_pkg::exe_param_t        i_param,
	output logic                           o_done,
	output logic [backend_pkg::TAG_W-1:0]  o_tag,
	output logic [backend_pkg::DATA_W-1:0] o_data
);

	import backend_pkg::*;

	logic [DATA_W-1:0] res;

	// wraps modulo 2^16 by truncation
	always_comb begin
		case (i_param.op)
			OP_LI:   res = {{(DATA_W - IMM_W){1'b0}}, i_param.imm};
			OP_ADD:  res = i_param.src1 + i_param.src2;
			OP_SUB:  res = i_param.src1 - i_param.src2;
			default: res = '0;
		endcase
	end

	always_ff @(posedge CLK or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_done <= 1'b0;
		end else begin
			o_done <= i_valid;
		end
	end

	always_ff @(posedge CLK) begin
		if (i_valid) begin
			o_tag  <= i_param.tag;
			o_data <= res;
		end
	end

endmodule

/* hw/mul_unit.sv */
`timescale 1ns/1ps

module mul_unit (
	input  logic                           CLK,
	input  logic                           i_arst_n,
	input  logic                           i_valid,
	input  backend_pkg::exe_param_t        i_param,
	output logic                           o_done,
	output logic [backend_pkg::TAG_W-1:0]  o_tag,
	output logic [backend_pkg::DATA_W-1:0] o_data
);

	import backend_pkg::*;

	logic [MUL_STAGES-1:0] stg_vld;
	logic [TAG_W-1:0]  stg_tag  [MUL_STAGES];
	logic [DATA_W-1:0] stg_prod [MUL_STAGES];
	logic [DATA_W-1:0] prod_lo;

	// product wraps modulo 2^16 by truncation
	assign prod_lo = i_param.src1 * i_param.src2;

	always_ff @(posedge CLK or negedge i_arst_n) begin
		if (!i_arst_n) begin
			stg_vld <= '0;
		end else begin
			stg_vld <= {stg_vld[MUL_STAGES-2:0], i_valid};
		end
	end

	// stage one forms the product and later stages carry it with its tag
	always_ff @(posedge CLK) begin
		stg_tag[0]  <= i_param.tag;
		stg_prod[0] <= prod_lo;
		for (int s = 1; s < MUL_STAGES; s++) begin
			stg_tag[s]  <= stg_tag[s-1];
			stg_prod[s] <= stg_prod[s-1];
		end
	end

	assign o_done = stg_vld[MUL_STAGES-1];
	assign o_tag  = stg_tag[MUL_STAGES-1];
	assign o_data = stg_prod[MUL_STAGES-1];

endmodule

/* hw/backend_ctrl.sv */
`timescale 1ns/1ps

module backend_ctrl (
	input  logic                           CLK,
	input  logic                           i_arst_n,
	input  backend_pkg::micro_instr_t      i_head,
	input  logic                           i_instr_empty,
	output logic                           o_instr_pop,
	output logic                           o_instr_credit,
	input  logic                           i_rob_full,
	input  logic [backend_pkg::TAG_W-1:0]  i_alloc_tag,
	output logic                           o_rob_alloc,
	output logic                           o_alu_push,
	input  logic                           i_alu_full,
	output logic                           o_mul_push,
	input  logic                           i_mul_full,
	output backend_pkg::exe_param_t        o_exe_param,
	input  logic [backend_pkg::DATA_W-1:0] i_rs1_data,
	input  logic [backend_pkg::DATA_W-1:0] i_rs2_data,
	input  logic                           i_head_done,
	input  logic [backend_pkg::REG_W-1:0]  i_head_rd,
	input  logic [backend_pkg::DATA_W-1:0] i_head_data,
	output logic                           o_retire,
	output logic                           o_wr_en,
	output logic [backend_pkg::REG_W-1:0]  o_wr_rd,
	output logic [backend_pkg::DATA_W-1:0] o_wr_data,
	output logic                           o_commit_valid,
	output logic [backend_pkg::REG_W-1:0]  o_commit_rd,
	output logic [backend_pkg::DATA_W-1:0] o_commit_data
);

	import backend_pkg::*;

	// scoreboard, in-flight writers per register
	logic [CNT_W-1:0] pend [NUM_REGS];
	logic is_mul;
	logic uses_src;
	logic src_busy;
	logic tgt_full;
	logic dispatch;

	assign is_mul   = (i_head.op == OP_MUL);
	assign uses_src = (i_head.op != OP_LI);
	assign src_busy = uses_src && ((pend[i_head.rs1] != '0) || (pend[i_head.rs2] != '0));
	assign tgt_full = is_mul ? i_mul_full : i_alu_full;
	assign dispatch = !i_instr_empty && !i_rob_full && !tgt_full && !src_busy;

	assign o_instr_pop = dispatch;
	assign o_rob_alloc = dispatch;
	assign o_alu_push  = dispatch && !is_mul;
	assign o_mul_push  = dispatch && is_mul;

	// operands come straight from the register file this cycle
	always_comb begin
		o_exe_param.op   = i_head.op;
		o_exe_param.tag  = i_alloc_tag;
		o_exe_param.src1 = i_rs1_data;
		o_exe_param.src2 = i_rs2_data;
		o_exe_param.imm  = i_head.imm;
	end

	// in-order retirement, one per cycle
	assign o_retire  = i_head_done;
	assign o_wr_en   = o_retire;
	assign o_wr_rd   = i_head_rd;
	assign o_wr_data = i_head_data;

	always_ff @(posedge CLK or negedge i_arst_n) begin
		if (!i_arst_n) begin
			for (int r = 0; r < NUM_REGS; r++) begin
				pend[r] <= '0;
			end
		end else begin
			for (int r = 0; r < NUM_REGS; r++) begin
				// dispatch and retire of the same rd cancel out
				if (dispatch && (i_head.rd == r) && !(o_retire && (i_head_rd == r))) begin
					pend[r] <= pend[r] + 1'b1;
				end else if (o_retire && (i_head_rd == r) && !(dispatch && (i_head.rd == r))) begin
					pend[r] <= pend[r] - 1'b1;
				end
			end
		end
	end

	// credit goes back the cycle after the queue entry is freed
	always_ff @(posedge CLK or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_instr_credit <= 1'b0;
			o_commit_valid <= 1'b0;
		end else begin
			o_instr_credit <= o_instr_pop;
			o_commit_valid <= o_retire;
		end
	end

	always_ff @(posedge CLK) begin
		if (o_retire) begin
			o_commit_rd   <= i_head_rd;
			o_commit_data <= i_head_data;
		end
	end

endmodule

/* hw/backend.sv */
`timescale 1ns/1ps

module backend (
	input  logic                           CLK,
	input  logic                           i_arst_n,
	input  logic                           i_instr_valid,
	input  backend_pkg::micro_instr_t      i_instr,
	output logic                           o_instr_credit,
	output logic                           o_commit_valid,
	output logic [backend_pkg::REG_W-1:0]  o_commit_rd,
	output logic [backend_pkg::DATA_W-1:0] o_commit_data
);

	import backend_pkg::*;

	// instruction queue
	micro_instr_t instr_head;
	logic instr_pop;
	logic instr_empty;

	// dispatch to issue
	exe_param_t exe_param;
	exe_param_t alu_param;
	exe_param_t mul_param;
	logic alu_push;
	logic alu_full;
	logic alu_empty;
	logic mul_push;
	logic mul_full;
	logic mul_empty;

	// units pop whenever work is waiting
	wire alu_issue = !alu_empty;
	wire mul_issue = !mul_empty;

	// completion
	logic alu_done;
	logic [TAG_W-1:0] alu_tag;
	logic [DATA_W-1:0] alu_data;
	logic mul_done;
	logic [TAG_W-1:0] mul_tag;
	logic [DATA_W-1:0] mul_data;

	// reorder buffer and register file
	logic rob_alloc;
	logic rob_full;
	logic [TAG_W-1:0] alloc_tag;
	logic retire;
	logic head_done;
	logic [REG_W-1:0] head_rd;
	logic [DATA_W-1:0] head_data;
	logic [DATA_W-1:0] rs1_data;
	logic [DATA_W-1:0] rs2_data;
	logic wr_en;
	logic [REG_W-1:0] wr_rd;
	logic [DATA_W-1:0] wr_data;

	// front end never overruns thanks to credits, so full is not needed
	issue_fifo #(.payload_t(micro_instr_t), .DEPTH(INSTR_CREDITS)) instr_queue (
		.CLK(CLK), .i_arst_n(i_arst_n),
		.i_push(i_instr_valid), .i_data(i_instr),
		.i_pop(instr_pop), .o_data(instr_head),
		.o_full(), .o_empty(instr_empty)
	);

	issue_fifo #(.payload_t(exe_param_t), .DEPTH(ISSUE_DEPTH)) alu_queue (
		.CLK(CLK), .i_arst_n(i_arst_n),
		.i_push(alu_push), .i_data(exe_param),
		.i_pop(alu_issue), .o_data(alu_param),
		.o_full(alu_full), .o_empty(alu_empty)
	);

	issue_fifo #(.payload_t(exe_param_t), .DEPTH(ISSUE_DEPTH)) mul_queue (
		.CLK(CLK), .i_arst_n(i_arst_n),
		.i_push(mul_push), .i_data(exe_param),
		.i_pop(mul_issue), .o_data(mul_param),
		.o_full(mul_full), .o_empty(mul_empty)
	);

	alu_unit alu_inst (
		.CLK(CLK), .i_arst_n(i_arst_n),
		.i_valid(alu_issue), .i_param(alu_param),
		.o_done(alu_done), .o_tag(alu_tag), .o_data(alu_data)
	);

	mul_unit mul_inst (
		.CLK(CLK), .i_arst_n(i_arst_n),
		.i_valid(mul_issue), .i_param(mul_param),
		.o_done(mul_done), .o_tag(mul_tag), .o_data(mul_data)
	);

	reorder_buf rob_inst (
		.CLK(CLK), .i_arst_n(i_arst_n),
		.i_alloc(rob_alloc), .i_alloc_rd(instr_head.rd),
		.o_alloc_tag(alloc_tag), .o_full(rob_full),
		.i_alu_done(alu_done), .i_alu_tag(alu_tag), .i_alu_data(alu_data),
		.i_mul_done(mul_done), .i_mul_tag(mul_tag), .i_mul_data(mul_data),
		.i_retire(retire), .o_head_done(head_done),
		.o_head_rd(head_rd), .o_head_data(head_data)
	);

	reg_file rf_inst (
		.CLK(CLK), .i_arst_n(i_arst_n),
		.i_rs1(instr_head.rs1), .i_rs2(instr_head.rs2),
		.o_rs1_data(rs1_data), .o_rs2_data(rs2_data),
		.i_wr_en(wr_en), .i_wr_rd(wr_rd), .i_wr_data(wr_data)
	);

	backend_ctrl ctrl_inst (
		.CLK(CLK), .i_arst_n(i_arst_n),
		.i_head(instr_head), .i_instr_empty(instr_empty),
		.o_instr_pop(instr_pop), .o_instr_credit(o_instr_credit),
		.i_rob_full(rob_full), .i_alloc_tag(alloc_tag), .o_rob_alloc(rob_alloc),
		.o_alu_push(alu_push), .i_alu_full(alu_full),
		.o_mul_push(mul_push), .i_mul_full(mul_full),
		.o_exe_param(exe_param),
		.i_rs1_data(rs1_data), .i_rs2_data(rs2_data),
		.i_head_done(head_done), .i_head_rd(head_rd), .i_head_data(head_data),
		.o_retire(retire), .o_wr_en(wr_en), .o_wr_rd(wr_rd), .o_wr_data(wr_data),
		.o_commit_valid(o_commit_valid), .o_commit_rd(o_commit_rd),
		.o_commit_data(o_commit_data)
	);

endmodule

/* test/backend_assert.sv */
`timescale 1ns/1ps

module backend_assert (
	input logic                           CLK,
	input logic                           i_arst_n,
	input logic                           i_instr_valid,
	input logic                           o_instr_credit,
	input logic                           o_commit_valid,
	input logic [backend_pkg::REG_W-1:0]  o_commit_rd,
	input logic [backend_pkg::DATA_W-1:0] o_commit_data
);

	int sends_seen;
	int credits_seen;
	int fail_count = 0;

	always_ff @(posedge CLK or negedge i_arst_n) begin
		if (!i_arst_n) begin
			sends_seen   <= 0;
			credits_seen <= 0;
		end else begin
			if (i_instr_valid) begin
				sends_seen <= sends_seen + 1;
			end
			if (o_instr_credit) begin
				credits_seen <= credits_seen + 1;
			end
		end
	end

	// outputs quiet in reset
	reset_quiet: assert property (@(posedge CLK)
		!i_arst_n |-> (!o_commit_valid && !o_instr_credit))
		else begin
			$error("commit or credit asserted during reset");
			fail_count++;
		end

	// and through the first cycles after release
	release_quiet: assert property (@(posedge CLK)
		$rose(i_arst_n) |-> (!o_commit_valid && !o_instr_credit)
			##1 (!o_commit_valid && !o_instr_credit))
		else begin
			$error("commit or credit asserted right after reset release");
			fail_count++;
		end

	// each credit pays back an earlier send
	credit_after_send: assert property (@(posedge CLK) disable iff (!i_arst_n)
		o_instr_credit |-> (credits_seen < sends_seen))
		else begin
			$error("credit returned without a matching earlier send");
			fail_count++;
		end

	commit_known: assert property (@(posedge CLK) disable iff (!i_arst_n)
		o_commit_valid |-> !$isunknown({o_commit_rd, o_commit_data}))
		else begin
			$error("commit rd or data unknown while valid");
			fail_count++;
		end

endmodule

bind backend backend_assert backend_assert_inst (
	.CLK(CLK),
	.i_arst_n(i_arst_n),
	.i_instr_valid(i_instr_valid),
	.o_instr_credit(o_instr_credit),
	.o_commit_valid(o_commit_valid),
	.o_commit_rd(o_commit_rd),
	.o_commit_data(o_commit_data)
);

/* test/tb_backend.sv */
`timescale 1ns/1ps

module tb_backend;

	import backend_pkg::*;

	localparam int CLK_PERIOD       = 100;
	localparam int RESET_CYCLES     = 5;
	localparam int NUM_LOADS        = NUM_REGS;
	localparam int NUM_RANDOM       = 200;
	localparam int NUM_TOTAL        = NUM_LOADS + NUM_RANDOM;
	localparam int CYCLES_PER_INSTR = 20;

	logic CLK;
	logic i_arst_n;
	logic i_instr_valid;
	micro_instr_t i_instr;
	logic o_instr_credit;
	logic o_commit_valid;
	logic [REG_W-1:0] o_commit_rd;
	logic [DATA_W-1:0] o_commit_data;

	// in-order reference model and its expected commits
	logic [DATA_W-1:0] model_regs [NUM_REGS];
	logic [REG_W-1:0] exp_rd [$];
	logic [DATA_W-1:0] exp_data [$];

	logic [31:0] rng_state;
	micro_instr_t next_instr;
	logic [REG_W-1:0] last_rd;
	int sent = 0;
	int returned = 0;
	int commits = 0;

	backend backend_inst (
		.CLK(CLK),
		.i_arst_n(i_arst_n),
		.i_instr_valid(i_instr_valid),
		.i_instr(i_instr),
		.o_instr_credit(o_instr_credit),
		.o_commit_valid(o_commit_valid),
		.o_commit_rd(o_commit_rd),
		.o_commit_data(o_commit_data)
	);

	always #(CLK_PERIOD / 2) CLK = ~CLK;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		$display("** Error at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
		$display("test failed");
		$fatal(1, "commit value mismatch");
	endtask

	task automatic abort_run(input string why);
		$display("%0t ns: %s", $time, why);
		$display("test failed");
		$fatal(1, "run aborted");
	endtask

	// executes at send time, so program order is the send order
	task automatic model_and_record(input micro_instr_t ins);
		logic [DATA_W-1:0] res;
		case (ins.op)
			OP_LI:   res = ins.imm;
			OP_ADD:  res = model_regs[ins.rs1] + model_regs[ins.rs2];
			OP_SUB:  res = model_regs[ins.rs1] - model_regs[ins.rs2];
			default: res = model_regs[ins.rs1] * model_regs[ins.rs2];
		endcase
		model_regs[ins.rd] = res;
		exp_rd.push_back(ins.rd);
		exp_data.push_back(res);
	endtask

	// first loads fill every register and random ops follow
	task automatic pick_instr(input int idx);
		rng_state = xorshift32(rng_state);
		if (idx < NUM_LOADS) begin
			next_instr.op  = OP_LI;
			next_instr.rd  = idx[REG_W-1:0];
			next_instr.rs1 = '0;
			next_instr.rs2 = '0;
		end else begin
			next_instr.op  = op_e'(rng_state[1:0]);
			next_instr.rd  = rng_state[4:2];
			// lean on the previous result to build dependency chains
			next_instr.rs1 = rng_state[9] ? last_rd : rng_state[7:5];
			next_instr.rs2 = rng_state[12:10];
		end
		next_instr.imm = rng_state[20:13];
	endtask

	initial begin
		CLK           = 1'b0;
		i_arst_n      = 1'b0;
		i_instr_valid = 1'b0;
		i_instr       = '0;
		rng_state     = 32'd98;
		last_rd       = '0;
		for (int r = 0; r < NUM_REGS; r++) begin
			model_regs[r] = '0;
		end
		repeat (RESET_CYCLES) @(posedge CLK);
		#1;
		i_arst_n = 1'b1;
		while (sent < NUM_TOTAL) begin
			@(posedge CLK);
			#1;
			rng_state = xorshift32(rng_state);
			// one credit must be in hand to send
			if ((sent - returned < INSTR_CREDITS) && (rng_state[31:30] != 2'b00)) begin
				pick_instr(sent);
				model_and_record(next_instr);
				last_rd       = next_instr.rd;
				i_instr       = next_instr;
				i_instr_valid = 1'b1;
				sent++;
			end else begin
				i_instr_valid = 1'b0;
			end
		end
		@(posedge CLK);
		#1;
		i_instr_valid = 1'b0;
		wait (commits == NUM_TOTAL);
		// quiet period so a stray extra commit is still seen
		repeat (10) @(posedge CLK);
		if ((commits == NUM_TOTAL) && (exp_rd.size() == 0)) begin
			$display("test passed");
			$finish;
		end else begin
			abort_run("commit count does not match the instructions sent");
		end
	end

	// outputs are sampled mid-cycle where they are settled
	always @(negedge CLK) begin
		if (i_arst_n) begin
			if (o_instr_credit) begin
				returned++;
			end
			assert ((sent - returned >= 0) && (sent - returned <= INSTR_CREDITS))
				else abort_run("instructions outstanding in the instruction queue out of range");
			assert (backend_inst.backend_assert_inst.fail_count == 0)
				else abort_run("a protocol assertion bound to the DUT failed");
			if (o_commit_valid) begin
				assert (exp_rd.size() != 0)
					else abort_run("commit arrived with no instruction outstanding");
				assert (o_commit_rd === exp_rd[0])
					else report_mismatch("o_commit_rd", exp_rd[0], o_commit_rd);
				assert (o_commit_data === exp_data[0])
					else report_mismatch("o_commit_data", exp_data[0], o_commit_data);
				void'(exp_rd.pop_front());
				void'(exp_data.pop_front());
				commits++;
			end
		end
	end

	initial begin
		#((RESET_CYCLES + NUM_TOTAL * CYCLES_PER_INSTR) * CLK_PERIOD);
		abort_run("watchdog expired, commits stopped before every instruction retired");
	end

endmodule

/* list.f */
hw/backend_pkg.sv
hw/issue_fifo.sv
hw/reorder_buf.sv
hw/reg_file.sv
hw/alu_unit.sv
hw/mul_unit.sv
hw/backend_ctrl.sv
hw/backend.sv
test/backend_assert.sv
test/tb_backend.sv

/* Bender.yml */
package:
  name: backend

sources:
  - files:
      - hw/backend_pkg.sv
      - hw/issue_fifo.sv
      - hw/reorder_buf.sv
      - hw/reg_file.sv
      - hw/alu_unit.sv
      - hw/mul_unit.sv
      - hw/backend_ctrl.sv
      - hw/backend.sv
  - target: test
    files:
      - test/backend_assert.sv
      - test/tb_backend.sv
